// ==== logic/audio_fmt_pkg.sv ====
// Audio sample formats
// Stereo sample word as seen from the register bus and from the I2S side
package audio_fmt_pkg;

    // Bits per channel sample
    localparam int SAMPLE_BITS = 16;

    // Bit clock periods in one stereo frame
    localparam int FRAME_BITS = 32;

    // Master clock periods per bit clock period, mclk = 256 x fs
    localparam int MCLK_PER_SCLK = 8;

    typedef logic signed [SAMPLE_BITS-1:0] sample_t;

    // Left channel in the upper half, right channel in the lower half
    typedef struct packed {
        sample_t left;
        sample_t right;
    } stereo_pair_t;

    // Raw bus word on one side, channel pair on the other
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        stereo_pair_t          pair;
    } stereo_word_t;

endpackage

// ==== logic/audio_regs_pkg.sv ====
// Audio peripheral register map
// Word offsets and bit positions of the control and status registers
package audio_regs_pkg;

    // Low address bits that select a register
    localparam int REG_ADDR_BITS = 4;

    // Register offsets
    localparam logic [REG_ADDR_BITS-1:0] REG_CTRL   = 4'h0;
    localparam logic [REG_ADDR_BITS-1:0] REG_STATUS = 4'h4;
    localparam logic [REG_ADDR_BITS-1:0] REG_DATA   = 4'h8;

    // Control register fields
    // Bit 0 starts the clocks and the stream
    localparam int CTRL_ENABLE_BIT = 0;
    // 8-bit low-water threshold
    localparam int CTRL_THRESH_LSB = 8;

    // Status register fields
    // FIFO fill level in bits 7:0
    localparam int STAT_LEVEL_LSB = 0;
    localparam int STAT_EMPTY_BIT = 8;
    localparam int STAT_FULL_BIT = 9;
    // Sticky flags, cleared by writing a 1
    localparam int STAT_UNDERRUN_BIT = 10;
    localparam int STAT_OVERFLOW_BIT = 11;

endpackage

// ==== logic/audio_bus_regs.sv ====
// Wishbone register slave of the audio peripheral
// Control and sticky status registers, sample push into the FIFO, low-water interrupt
module audio_bus_regs
    import audio_fmt_pkg::*;
    import audio_regs_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst_i,
    input  logic [31:0]  wb_adr_i,
    input  logic [31:0]  wb_dat_i,
    output logic [31:0]  wb_dat_o,
    input  logic         wb_we_i,
    input  logic         wb_stb_i,
    output logic         wb_ack_o,
    input  logic [7:0]   level_i,
    input  logic         empty_i,
    input  logic         full_i,
    input  logic         underrun_i,
    output logic         push_o,
    output stereo_word_t push_data_o,
    output logic         enable_o,
    output logic         fifo_low_o
);

    logic                     ack_q;
    logic [31:0]              rd_data_q;
    logic                     ctrl_enable_q;
    logic [7:0]               ctrl_thresh_q;
    logic                     underrun_q;
    logic                     overflow_q;
    logic                     fifo_low_q;
    logic [REG_ADDR_BITS-1:0] reg_sel;
    logic                     wr_ack;
    logic                     wr_ctrl;
    logic                     wr_status;
    logic                     wr_data;
    logic [7:0]               thresh_eff;
    logic [31:0]              ctrl_word;
    logic [31:0]              status_word;
    logic [31:0]              rd_mux;

    // Base address is decoded by the interconnect
    assign reg_sel = wb_adr_i[REG_ADDR_BITS-1:0];

    // Writes take effect in the ack cycle
    assign wr_ack    = ack_q & wb_we_i;
    assign wr_ctrl   = wr_ack & (reg_sel == REG_CTRL);
    assign wr_status = wr_ack & (reg_sel == REG_STATUS);
    assign wr_data   = wr_ack & (reg_sel == REG_DATA);

    // A full FIFO drops the word
    assign push_o          = wr_data & ~full_i;
    assign push_data_o.raw = wb_dat_i;

    // Threshold above the depth behaves as the depth
    assign thresh_eff = (ctrl_thresh_q > FIFO_DEPTH) ? 8'(FIFO_DEPTH) : ctrl_thresh_q;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[CTRL_ENABLE_BIT] = ctrl_enable_q;
        ctrl_word[CTRL_THRESH_LSB +: 8] = ctrl_thresh_q;

        status_word = '0;
        status_word[STAT_LEVEL_LSB +: 8] = level_i;
        status_word[STAT_EMPTY_BIT] = empty_i;
        status_word[STAT_FULL_BIT] = full_i;
        status_word[STAT_UNDERRUN_BIT] = underrun_q;
        status_word[STAT_OVERFLOW_BIT] = overflow_q;

        // Data register is write only
        case (reg_sel)
            REG_CTRL:   rd_mux = ctrl_word;
            REG_STATUS: rd_mux = status_word;
            default:    rd_mux = '0;
        endcase
    end

    // Single cycle ack, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_stb_i & ~ack_q;
        end
    end

    // Read data captured so it is stable in the ack cycle
    always_ff @(posedge clk) begin
        if (wb_stb_i && !ack_q) begin
            rd_data_q <= rd_mux;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ctrl_enable_q <= 1'b0;
            ctrl_thresh_q <= '0;
            underrun_q    <= 1'b0;
            overflow_q    <= 1'b0;
            fifo_low_q    <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                ctrl_enable_q <= wb_dat_i[CTRL_ENABLE_BIT];
                ctrl_thresh_q <= wb_dat_i[CTRL_THRESH_LSB +: 8];
            end

            // New events win over a clear in the same cycle
            if (underrun_i) begin
                underrun_q <= 1'b1;
            end else if (wr_status && wb_dat_i[STAT_UNDERRUN_BIT]) begin
                underrun_q <= 1'b0;
            end

            if (wr_data && full_i) begin
                overflow_q <= 1'b1;
            end else if (wr_status && wb_dat_i[STAT_OVERFLOW_BIT]) begin
                overflow_q <= 1'b0;
            end

            fifo_low_q <= ctrl_enable_q && (level_i < thresh_eff);
        end
    end

    assign wb_ack_o   = ack_q;
    assign wb_dat_o   = rd_data_q;
    assign enable_o   = ctrl_enable_q;
    assign fifo_low_o = fifo_low_q;

endmodule

// ==== logic/sample_fifo.sv ====
// Stereo sample FIFO
// Circular buffer with first-word-fall-through read and fill level
module sample_fifo
    import audio_fmt_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
) (
    input  logic         clk,
    input  logic         rst_i,
    input  logic         push_i,
    input  stereo_word_t push_data_i,
    input  logic         pop_i,
    output stereo_word_t rd_data_o,
    output logic [7:0]   level_o,
    output logic         empty_o,
    output logic         full_o
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);

    stereo_word_t        mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS:0]   count_q;
    logic                do_push;
    logic                do_pop;

    assign full_o  = (count_q == (PTR_BITS+1)'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);

    // Push while full and pop while empty have no effect
    assign do_push = push_i & ~full_o;
    assign do_pop  = pop_i & ~empty_o;

    // Storage array
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Head word is visible without a read request
    assign rd_data_o = mem[rd_ptr_q];
    assign level_o   = 8'(count_q);

endmodule

// ==== logic/i2s_clkgen.sv ====
// I2S clock generator
// Master, bit and word clocks from the system clock, with bit and frame strobes
module i2s_clkgen
    import audio_fmt_pkg::*;
#(
    parameter int MCLK_HALF = 2
) (
    input  logic clk,
    input  logic rst_i,
    input  logic enable_i,
    output logic i2s_mclk_o,
    output logic i2s_sclk_o,
    output logic i2s_lrclk_o,
    output logic bit_stb_o,
    output logic frame_stb_o
);

    localparam int PRE_BITS  = (MCLK_HALF > 1) ? $clog2(MCLK_HALF) : 1;
    localparam int HALF_BITS = $clog2(MCLK_PER_SCLK);
    localparam int BIT_BITS  = $clog2(FRAME_BITS);

    logic [PRE_BITS-1:0]  pre_cnt_q;
    logic [HALF_BITS-1:0] half_cnt_q;
    logic [BIT_BITS-1:0]  bit_cnt_q;
    logic                 mclk_q;
    logic                 sclk_q;
    logic                 mclk_tick;
    logic                 sclk_tick;
    logic                 sclk_fall;

    // One tick per master clock half period
    assign mclk_tick = enable_i && (pre_cnt_q == PRE_BITS'(MCLK_HALF - 1));
    // Bit clock toggles every MCLK_PER_SCLK master half periods
    assign sclk_tick = mclk_tick && (half_cnt_q == HALF_BITS'(MCLK_PER_SCLK - 1));
    assign sclk_fall = sclk_tick && sclk_q;

    // Disable holds every counter at zero
    always_ff @(posedge clk) begin
        if (rst_i || !enable_i) begin
            pre_cnt_q  <= '0;
            half_cnt_q <= '0;
            bit_cnt_q  <= '0;
            mclk_q     <= 1'b0;
            sclk_q     <= 1'b0;
        end else begin
            if (mclk_tick) begin
                pre_cnt_q  <= '0;
                mclk_q     <= ~mclk_q;
                half_cnt_q <= half_cnt_q + 1'b1;
            end else begin
                pre_cnt_q <= pre_cnt_q + 1'b1;
            end
            if (sclk_tick) begin
                sclk_q <= ~sclk_q;
            end
            if (sclk_fall) begin
                bit_cnt_q <= bit_cnt_q + 1'b1;
            end
        end
    end

    // Strobes mark the cycle that ends with the bit clock falling
    assign bit_stb_o   = sclk_fall;
    assign frame_stb_o = sclk_fall && (bit_cnt_q == BIT_BITS'(FRAME_BITS - 1));

    assign i2s_mclk_o  = mclk_q;
    assign i2s_sclk_o  = sclk_q;
    // Low for left, high for right
    assign i2s_lrclk_o = bit_cnt_q[BIT_BITS-1];

endmodule

// ==== logic/i2s_serializer.sv ====
// I2S data serializer
// Shifts one stereo word per frame out MSB first, one bit behind the word clock
module i2s_serializer
    import audio_fmt_pkg::*;
(
    input  logic         clk,
    input  logic         rst_i,
    input  logic         bit_stb_i,
    input  logic         frame_stb_i,
    input  stereo_word_t fifo_data_i,
    input  logic         fifo_empty_i,
    output logic         pop_o,
    output logic         underrun_o,
    output logic         i2s_sdata_o
);

    logic [FRAME_BITS-1:0] shift_q;
    logic                  sdata_q;
    logic [FRAME_BITS-1:0] load_word;

    // Left sample leaves first so it goes on top, silence on an empty FIFO
    always_comb begin
        if (fifo_empty_i) begin
            load_word = '0;
        end else begin
            load_word = {fifo_data_i.pair.left, fifo_data_i.pair.right};
        end
    end

    // One word taken per frame
    assign pop_o      = frame_stb_i & ~fifo_empty_i;
    assign underrun_o = frame_stb_i & fifo_empty_i;

    // sdata_q is the delay stage, it carries the previous frame's
    // last bit across the word clock edge
    always_ff @(posedge clk) begin
        if (rst_i) begin
            shift_q <= '0;
            sdata_q <= 1'b0;
        end else if (bit_stb_i) begin
            sdata_q <= shift_q[FRAME_BITS-1];
            if (frame_stb_i) begin
                shift_q <= load_word;
            end else begin
                shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
            end
        end
    end

    assign i2s_sdata_o = sdata_q;

endmodule

// ==== logic/audio_top.sv ====
// Audio peripheral top
// Register slave, sample FIFO, I2S clock generator and serializer
module audio_top
    import audio_fmt_pkg::*;
#(
    parameter int FIFO_DEPTH = 16,
    parameter int MCLK_HALF  = 2
) (
    input  logic        clk,
    input  logic        rst_i,

    // Register bus
    input  logic [31:0] wb_adr_i,
    input  logic [31:0] wb_dat_i,
    output logic [31:0] wb_dat_o,
    input  logic        wb_we_i,
    input  logic        wb_stb_i,
    output logic        wb_ack_o,

    // Interrupt level
    output logic        fifo_low_o,

    // I2S
    output logic        i2s_mclk_o,
    output logic        i2s_sclk_o,
    output logic        i2s_lrclk_o,
    output logic        i2s_sdata_o
);

    logic         push;
    stereo_word_t push_data;
    logic         pop;
    stereo_word_t rd_data;
    logic [7:0]   level;
    logic         empty;
    logic         full;
    logic         underrun;
    logic         enable;
    logic         bit_stb;
    logic         frame_stb;

    audio_bus_regs #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) audio_bus_regs_i (
        .clk(clk),
        .rst_i(rst_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_we_i(wb_we_i),
        .wb_stb_i(wb_stb_i),
        .wb_ack_o(wb_ack_o),
        .level_i(level),
        .empty_i(empty),
        .full_i(full),
        .underrun_i(underrun),
        .push_o(push),
        .push_data_o(push_data),
        .enable_o(enable),
        .fifo_low_o(fifo_low_o)
    );

    sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) sample_fifo_i (
        .clk(clk),
        .rst_i(rst_i),
        .push_i(push),
        .push_data_i(push_data),
        .pop_i(pop),
        .rd_data_o(rd_data),
        .level_o(level),
        .empty_o(empty),
        .full_o(full)
    );

    i2s_clkgen #(
        .MCLK_HALF(MCLK_HALF)
    ) i2s_clkgen_i (
        .clk(clk),
        .rst_i(rst_i),
        .enable_i(enable),
        .i2s_mclk_o(i2s_mclk_o),
        .i2s_sclk_o(i2s_sclk_o),
        .i2s_lrclk_o(i2s_lrclk_o),
        .bit_stb_o(bit_stb),
        .frame_stb_o(frame_stb)
    );

    i2s_serializer i2s_serializer_i (
        .clk(clk),
        .rst_i(rst_i),
        .bit_stb_i(bit_stb),
        .frame_stb_i(frame_stb),
        .fifo_data_i(rd_data),
        .fifo_empty_i(empty),
        .pop_o(pop),
        .underrun_o(underrun),
        .i2s_sdata_o(i2s_sdata_o)
    );

endmodule

// ==== tb/audio_tb_tasks.svh ====
// Bus access, checking, wait helpers and directed tests for the audio testbench

// Clock selectors for edge counting
localparam int SEL_MCLK  = 0;
localparam int SEL_SCLK  = 1;
localparam int SEL_LRCLK = 2;

function automatic logic [31:0] ctrl_word(input logic enable, input logic [7:0] thresh);
    logic [31:0] w;
    w = '0;
    w[CTRL_ENABLE_BIT] = enable;
    w[CTRL_THRESH_LSB +: 8] = thresh;
    return w;
endfunction

function automatic logic [31:0] status_word(input int level, input logic empty,
                                            input logic full, input logic underrun,
                                            input logic overflow);
    logic [31:0] w;
    w = '0;
    w[STAT_LEVEL_LSB +: 8] = 8'(level);
    w[STAT_EMPTY_BIT] = empty;
    w[STAT_FULL_BIT] = full;
    w[STAT_UNDERRUN_BIT] = underrun;
    w[STAT_OVERFLOW_BIT] = overflow;
    return w;
endfunction

function automatic logic clock_level(input int sel);
    case (sel)
        SEL_MCLK: return i2s_mclk_o;
        SEL_SCLK: return i2s_sclk_o;
        default:  return i2s_lrclk_o;
    endcase
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("** Error: %s is 0x%08h, expected 0x%08h", name, got, exp);
        abort_run();
    end
endtask

task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    abort_run();
endtask

// One bus access, the ack must come exactly one cycle after the strobe
task automatic register_access(input logic we, input logic [31:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_adr_i <= addr;
    wb_dat_i <= wdata;
    wb_we_i  <= we;
    wb_stb_i <= 1'b1;
    @(negedge clk);
    while (!wb_ack_o) begin
        if (waited >= BUS_TIMEOUT) begin
            report_timeout("the bus acknowledge");
        end
        @(negedge clk);
        waited++;
    end
    check_value("wb_ack_o delay in cycles", waited, 1);
    rdata = wb_dat_o;
    @(posedge clk);
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
endtask

task automatic write_register(input logic [3:0] addr, input logic [31:0] data);
    logic [31:0] unused;
    register_access(1'b1, 32'(addr), data, unused);
endtask

task automatic read_register(input logic [3:0] addr, output logic [31:0] data);
    register_access(1'b0, 32'(addr), '0, data);
endtask

task automatic push_words(input int n);
    logic [31:0] w;
    for (int i = 0; i < n; i++) begin
        w = $urandom();
        sent_words.push_back(w);
        write_register(REG_DATA, w);
    end
endtask

// Only while the clocks are stopped, first frame after enable is stale
task automatic reset_receiver();
    rx_frames.delete();
    rx_shift = '0;
    rx_left = '0;
    rx_lr_prev = 1'b0;
    rx_half_edges = 0;
    rx_skip = 1;
endtask

task automatic start_stream(input logic [7:0] thresh);
    write_register(REG_CTRL, ctrl_word(1'b1, thresh));
endtask

task automatic stop_stream(input logic [7:0] thresh);
    write_register(REG_CTRL, ctrl_word(1'b0, thresh));
    repeat (2) @(negedge clk);
    reset_receiver();
endtask

task automatic clear_flags();
    logic [31:0] w;
    w = '0;
    w[STAT_UNDERRUN_BIT] = 1'b1;
    w[STAT_OVERFLOW_BIT] = 1'b1;
    write_register(REG_STATUS, w);
endtask

task automatic wait_frames(input int n);
    int waited;
    waited = 0;
    while (rx_frames.size() < n) begin
        if (waited >= (n + 2) * FRAME_CYCLES) begin
            report_timeout("received I2S frames");
        end
        @(negedge clk);
        waited++;
    end
endtask

task automatic compare_frames(input int n);
    for (int i = 0; i < n; i++) begin
        check_value("rx left sample", rx_frames[i][31:16], sent_words[i][31:16]);
        check_value("rx right sample", rx_frames[i][15:0], sent_words[i][15:0]);
    end
endtask

// Counts rises of one clock across a number of edges of another
task automatic count_rises(input int ref_sel, input int cnt_sel, input int spans,
                           output int n);
    logic ref_prev;
    logic cnt_prev;
    int   changes;
    int   waited;
    n = 0;
    changes = 0;
    waited = 0;
    @(negedge clk);
    ref_prev = clock_level(ref_sel);
    cnt_prev = clock_level(cnt_sel);
    while (changes <= spans) begin
        if (waited >= 2 * FRAME_CYCLES) begin
            report_timeout("an I2S clock edge");
        end
        @(negedge clk);
        waited++;
        if (changes > 0 && clock_level(cnt_sel) && !cnt_prev) begin
            n++;
        end
        if (clock_level(ref_sel) != ref_prev) begin
            changes++;
        end
        ref_prev = clock_level(ref_sel);
        cnt_prev = clock_level(cnt_sel);
    end
endtask

task automatic reset_and_register_access();
    logic [31:0] rd;
    @(negedge clk);
    check_value("i2s_mclk_o", i2s_mclk_o, 0);
    check_value("i2s_sclk_o", i2s_sclk_o, 0);
    check_value("i2s_lrclk_o", i2s_lrclk_o, 0);
    check_value("i2s_sdata_o", i2s_sdata_o, 0);
    check_value("fifo_low_o", fifo_low_o, 0);
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b0, 1'b0));
    write_register(REG_CTRL, ctrl_word(1'b0, 8'h5a));
    read_register(REG_CTRL, rd);
    check_value("ctrl", rd, ctrl_word(1'b0, 8'h5a));
    write_register(REG_CTRL, ctrl_word(1'b1, 8'hc3));
    read_register(REG_CTRL, rd);
    check_value("ctrl", rd, ctrl_word(1'b1, 8'hc3));
    read_register(REG_DATA, rd);
    check_value("data register readback", rd, 0);
    stop_stream(8'h00);
    read_register(REG_CTRL, rd);
    check_value("ctrl", rd, ctrl_word(1'b0, 8'h00));
endtask

task automatic sample_stream();
    logic [31:0] rd;
    sent_words.delete();
    push_words(8);
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(8, 1'b0, 1'b0, 1'b0, 1'b0));
    start_stream(8'h00);
    wait_frames(8);
    compare_frames(8);
    stop_stream(8'h00);
    clear_flags();
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b0, 1'b0));
endtask

task automatic underrun_handling();
    logic [31:0] rd;
    logic [31:0] w;
    start_stream(8'h00);
    wait_frames(2);
    check_value("rx frame during underrun", rx_frames[0], 0);
    check_value("rx frame during underrun", rx_frames[1], 0);
    stop_stream(8'h00);
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b1, 1'b0));
    w = '0;
    w[STAT_UNDERRUN_BIT] = 1'b1;
    write_register(REG_STATUS, w);
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(0, 1'b1, 1'b0, 1'b0, 1'b0));
endtask

task automatic overflow_handling();
    logic [31:0] rd;
    sent_words.delete();
    push_words(FIFO_DEPTH + 3);
    read_register(REG_STATUS, rd);
    check_value("status", rd, status_word(FIFO_DEPTH, 1'b0, 1'b1, 1'b0, 1'b1));
    start_stream(8'h00);
    wait_frames(FIFO_DEPTH + 1);
    compare_frames(FIFO_DEPTH);
    // Dropped words never reach the stream
    check_value("rx frame after the stored words", rx_frames[FIFO_DEPTH], 0);
    stop_stream(8'h00);
    clear_flags();
endtask

task automatic low_water_interrupt();
    logic [31:0] st_a;
    logic [31:0] st_b;
    logic        low;
    logic        saw_high;
    logic        saw_low;
    int          polls;
    saw_high = 1'b0;
    saw_low = 1'b0;
    polls = 0;
    // Empty FIFO is below the threshold but the block is off
    write_register(REG_CTRL, ctrl_word(1'b0, 8'd4));
    repeat (2) @(negedge clk);
    check_value("fifo_low_o", fifo_low_o, 0);
    sent_words.delete();
    push_words(6);
    start_stream(8'd4);
    st_b = '1;
    while (st_b[7:0] != 8'd0) begin
        if (polls >= 4000) begin
            report_timeout("the FIFO to drain");
        end
        read_register(REG_STATUS, st_a);
        @(negedge clk);
        low = fifo_low_o;
        read_register(REG_STATUS, st_b);
        // Compare only when the level held still across the sample
        if (st_a[7:0] == st_b[7:0]) begin
            check_value("fifo_low_o", low, st_a[7:0] < 8'd4);
            if (low) begin
                saw_high = 1'b1;
            end else begin
                saw_low = 1'b1;
            end
        end
        polls++;
    end
    check_value("fifo_low_o seen high", saw_high, 1);
    check_value("fifo_low_o seen low", saw_low, 1);
    stop_stream(8'd4);
    check_value("fifo_low_o", fifo_low_o, 0);
    clear_flags();
endtask

task automatic clock_ratios();
    int n;
    start_stream(8'h00);
    for (int k = 0; k < 3; k++) begin
        count_rises(SEL_SCLK, SEL_MCLK, 2, n);
        check_value("i2s_mclk_o periods per i2s_sclk_o period", n, MCLK_PER_SCLK);
    end
    for (int k = 0; k < 2; k++) begin
        count_rises(SEL_LRCLK, SEL_SCLK, 1, n);
        check_value("i2s_sclk_o periods per i2s_lrclk_o half", n, FRAME_BITS / 2);
    end
    stop_stream(8'h00);
    clear_flags();
endtask

// ==== tb/audio_tb.sv ====
// Testbench for the audio peripheral
// Acts as the CPU on the register bus and receives the I2S stream
module audio_tb
    import audio_fmt_pkg::*;
    import audio_regs_pkg::*;
();

    localparam int FIFO_DEPTH   = 16;
    localparam int MCLK_HALF    = 2;
    localparam int FRAME_CYCLES = FRAME_BITS * 2 * MCLK_PER_SCLK * MCLK_HALF;
    localparam int BUS_TIMEOUT  = 16;

    logic        clk = 1'b0;
    logic        rst_i;
    logic [31:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_we_i;
    logic        wb_stb_i;
    logic        wb_ack_o;
    logic        fifo_low_o;
    logic        i2s_mclk_o;
    logic        i2s_sclk_o;
    logic        i2s_lrclk_o;
    logic        i2s_sdata_o;

    // Words written to the data register, in order
    logic [31:0] sent_words[$];

    // Receiver model state
    logic [15:0] rx_shift;
    logic [15:0] rx_left;
    logic        rx_lr_prev;
    int          rx_half_edges;
    int          rx_skip;
    logic [31:0] rx_frames[$];

    always #10 clk = ~clk;

    audio_top #(
        .FIFO_DEPTH(FIFO_DEPTH),
        .MCLK_HALF(MCLK_HALF)
    ) audio_top_i (
        .clk(clk),
        .rst_i(rst_i),
        .wb_adr_i(wb_adr_i),
        .wb_dat_i(wb_dat_i),
        .wb_dat_o(wb_dat_o),
        .wb_we_i(wb_we_i),
        .wb_stb_i(wb_stb_i),
        .wb_ack_o(wb_ack_o),
        .fifo_low_o(fifo_low_o),
        .i2s_mclk_o(i2s_mclk_o),
        .i2s_sclk_o(i2s_sclk_o),
        .i2s_lrclk_o(i2s_lrclk_o),
        .i2s_sdata_o(i2s_sdata_o)
    );

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    `include "audio_tb_tasks.svh"

    // I2S receiver, samples data and word clock on the bit clock rising edge
    always @(posedge i2s_sclk_o) begin
        rx_shift = {rx_shift[14:0], i2s_sdata_o};
        if (i2s_lrclk_o != rx_lr_prev) begin
            // One-bit delay puts a channel's LSB just after the word clock edge
            check_value("i2s_sclk_o periods per word clock half", rx_half_edges,
                        FRAME_BITS / 2);
            if (!rx_lr_prev) begin
                rx_left = rx_shift;
            end else if (rx_skip > 0) begin
                rx_skip--;
            end else begin
                rx_frames.push_back({rx_left, rx_shift});
            end
            rx_half_edges = 1;
        end else begin
            rx_half_edges++;
        end
        rx_lr_prev = i2s_lrclk_o;
    end

    initial begin
        void'($urandom(32'hfd74));
        rst_i    = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i  = 1'b0;
        wb_stb_i = 1'b0;
        reset_receiver();
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;

        reset_and_register_access();
        sample_stream();
        underrun_handling();
        overflow_handling();
        low_water_interrupt();
        clock_ratios();

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+tb
logic/audio_fmt_pkg.sv
logic/audio_regs_pkg.sv
logic/audio_bus_regs.sv
logic/sample_fifo.sv
logic/i2s_clkgen.sv
logic/i2s_serializer.sv
logic/audio_top.sv
tb/audio_tb.sv
